/* common/tsconf_defs.svh */
`ifndef TSCONF_DEFS_SVH
`define TSCONF_DEFS_SVH

// extended port space, low address byte
`define ZP_EXT_LO   8'hAF

// high address bytes of the extended ports
`define ZP_BORDER   8'h0F
`define ZP_PAGE0    8'h10   // pages 1..3 follow at 11..13
`define ZP_SYSCONF  8'h20
`define ZP_MEMCONF  8'h21
`define ZP_INTMASK  8'h2A

// im2 vectors, highest priority first
`define IV_FRAME    8'hFF
`define IV_LINE     8'hFD
`define IV_DMA      8'hFB

// reset values
`define RST_MEMCONF 8'h01   // rom in window 0
`define RST_INTMASK 3'b001  // frame int only
`define RST_PAGE3   8'h05

`endif

/* common/tsconf_pkg.sv */
`default_nettype none

package tsconf_pkg;

  // z80 side
  typedef logic [15:0] zaddr_t;
  typedef logic [7:0]  zdata_t;

  // 16k page number
  typedef logic [7:0]  page_t;

  // page followed by 14 bit offset
  typedef logic [21:0] maddr_t;

  // bit 0 frame, bit 1 line, bit 2 dma
  typedef logic [2:0]  intmask_t;

endpackage

`default_nettype wire

/* hdl/zint.sv */
`timescale 1ns/10ps
`default_nettype none
`include "tsconf_defs.svh"

module zint (
  input  logic                 fclk,
  input  logic                 rst,
  input  tsconf_pkg::intmask_t intmask,
  input  logic                 int_start_frm,
  input  logic                 int_start_lin,
  input  logic                 int_start_dma,
  input  logic                 intack,
  output logic                 int_n,
  output tsconf_pkg::zdata_t   int_dout,
  output logic                 int_oe
);

  import tsconf_pkg::*;

  intmask_t req;
  intmask_t pend;
  intmask_t grant;
  intmask_t ack_sel;     // source handed out in the current ack
  intmask_t ack_clr;
  logic     intack_d;

  // masked starts are simply dropped
  assign req = {int_start_dma, int_start_lin, int_start_frm} & intmask;

  // frame over line over dma
  always_comb begin
    grant    = 3'b000;
    int_dout = `IV_FRAME;   // nothing pending reads as frame vector
    if (pend[0]) begin
      grant    = 3'b001;
      int_dout = `IV_FRAME;
    end else if (pend[1]) begin
      grant    = 3'b010;
      int_dout = `IV_LINE;
    end else if (pend[2]) begin
      grant    = 3'b100;
      int_dout = `IV_DMA;
    end
  end

  assign int_oe  = intack;
  assign ack_clr = (intack_d & ~intack) ? ack_sel : 3'b000;

  always_ff @(posedge fclk) begin
    if (rst) begin
      pend     <= '0;
      ack_sel  <= '0;
      intack_d <= 1'b0;
      int_n    <= 1'b1;
    end else begin
      pend     <= (pend & ~ack_clr) | req;  // new request wins over clear
      intack_d <= intack;
      int_n    <= ~|pend;
      if (intack) begin
        ack_sel <= grant;
      end
    end
  end

  // a pending source only goes away at the end of an ack
  a_int_pending: assert property (@(posedge fclk) disable iff (rst)
    !int_n |-> (|pend || $past(intack_d && !intack)));

endmodule

`default_nettype wire

/* hdl/zmap.sv */
`timescale 1ns/10ps
`default_nettype none

module zmap (
  input  logic               fclk,
  input  logic               rst,
  input  tsconf_pkg::zaddr_t a,
  input  logic               mreq_s,
  input  tsconf_pkg::page_t  page0,
  input  tsconf_pkg::page_t  page1,
  input  tsconf_pkg::page_t  page2,
  input  tsconf_pkg::page_t  page3,
  input  logic               rom_w0,
  output tsconf_pkg::maddr_t mem_addr,
  output logic               csrom,
  output logic               mem_req
);

  import tsconf_pkg::*;

  logic [1:0] win;
  page_t      win_page;

  assign win = a[15:14];

  always_comb begin
    case (win)
      2'd0:    win_page = page0;
      2'd1:    win_page = page1;
      2'd2:    win_page = page2;
      default: win_page = page3;
    endcase
  end

  assign mem_addr = {win_page, a[13:0]};
  assign csrom    = rom_w0 & (win == 2'd0);   // rom only in window 0

  always_ff @(posedge fclk) begin
    if (rst) begin
      mem_req <= 1'b0;
    end else begin
      mem_req <= mreq_s;
    end
  end

  a_req_single: assert property (@(posedge fclk) disable iff (rst) mem_req |=> !mem_req);

endmodule

`default_nettype wire

/* hdl/zx_top.sv */
`timescale 1ns/10ps
`default_nettype none

module zx_top (
  input  logic               fclk,
  input  logic               rst,
  input  tsconf_pkg::zaddr_t a,
  input  tsconf_pkg::zdata_t d_in,
  input  logic               iorq_n,
  input  logic               mreq_n,
  input  logic               rd_n,
  input  logic               wr_n,
  input  logic               m1_n,
  input  logic               int_start_frm,
  input  logic               int_start_lin,
  input  logic               int_start_dma,
  output tsconf_pkg::zdata_t d_out,
  output logic               d_oe,
  output logic               int_n,
  output tsconf_pkg::maddr_t mem_addr,
  output logic               csrom,
  output logic               mem_req
);

  import tsconf_pkg::*;

  logic     iord;
  logic     iowr;
  logic     memrd;
  logic     memwr;
  logic     intack;
  logic     iowr_s;
  logic     mreq_s;
  logic     intack_s;
  zdata_t   port_dout;
  logic     port_oe;
  page_t    page0;
  page_t    page1;
  page_t    page2;
  page_t    page3;
  zdata_t   memconf;
  intmask_t intmask;
  zdata_t   int_dout;
  logic     int_oe;

  zsignals u_zsignals (
    .fclk     (fclk),
    .rst      (rst),
    .iorq_n   (iorq_n),
    .mreq_n   (mreq_n),
    .rd_n     (rd_n),
    .wr_n     (wr_n),
    .m1_n     (m1_n),
    .iord     (iord),
    .iowr     (iowr),
    .memrd    (memrd),
    .memwr    (memwr),
    .intack   (intack),
    .iowr_s   (iowr_s),
    .mreq_s   (mreq_s),
    .intack_s (intack_s)
  );

  zports u_zports (
    .fclk      (fclk),
    .rst       (rst),
    .a         (a),
    .d_in      (d_in),
    .iord      (iord),
    .iowr_s    (iowr_s),
    .port_dout (port_dout),
    .port_oe   (port_oe),
    .page0     (page0),
    .page1     (page1),
    .page2     (page2),
    .page3     (page3),
    .memconf   (memconf),
    .intmask   (intmask)
  );

  zmap u_zmap (
    .fclk     (fclk),
    .rst      (rst),
    .a        (a),
    .mreq_s   (mreq_s),
    .page0    (page0),
    .page1    (page1),
    .page2    (page2),
    .page3    (page3),
    .rom_w0   (memconf[0]),
    .mem_addr (mem_addr),
    .csrom    (csrom),
    .mem_req  (mem_req)
  );

  zint u_zint (
    .fclk          (fclk),
    .rst           (rst),
    .intmask       (intmask),
    .int_start_frm (int_start_frm),
    .int_start_lin (int_start_lin),
    .int_start_dma (int_start_dma),
    .intack        (intack),
    .int_n         (int_n),
    .int_dout      (int_dout),
    .int_oe        (int_oe)
  );

  assign d_out = intack ? int_dout : port_dout;   // vector wins during ack
  assign d_oe  = port_oe | int_oe;

  // bus is never driven on writes or memory cycles
  a_no_drive: assert property (@(posedge fclk) disable iff (rst)
    (iowr || memrd || memwr) |-> !d_oe);
  a_ack_drive: assert property (@(posedge fclk) disable iff (rst) intack_s |-> d_oe);

endmodule

`default_nettype wire

/* project.f */
+incdir+common
common/tsconf_pkg.sv
zports/zsignals.sv
zports/zports.sv
hdl/zmap.sv
hdl/zint.sv
hdl/zx_top.sv
verif/tb_zx_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_zx_top \
  -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi
exit 0

/* verif/tb_zx_top.sv */
`timescale 1ns/10ps
`default_nettype none
`include "tsconf_defs.svh"

module tb_zx_top;

  import tsconf_pkg::*;

  localparam int PERIOD = 40;
  localparam int N_IO   = 200;
  localparam int N_MEM  = 200;
  localparam int N_INT  = 100;
  localparam int N_ACK  = 150;
  localparam int MAX_OP = 14;   // two bus cycles, in clocks
  localparam longint WATCHDOG_NS =
    2 * (10 + (12 + N_IO + N_MEM + N_INT + 20 + N_ACK) * MAX_OP) * PERIOD;

  logic     fclk;
  logic     rst;
  zaddr_t   a;
  zdata_t   d_in;
  logic     iorq_n;
  logic     mreq_n;
  logic     rd_n;
  logic     wr_n;
  logic     m1_n;
  logic     int_start_frm;
  logic     int_start_lin;
  logic     int_start_dma;
  zdata_t   d_out;
  logic     d_oe;
  logic     int_n;
  maddr_t   mem_addr;
  logic     csrom;
  logic     mem_req;

  // reference state
  zdata_t   m_border;
  zdata_t   m_sysconf;
  zdata_t   m_memconf;
  page_t    m_page [4];
  intmask_t m_mask;
  intmask_t m_pend;

  zdata_t listed [8] = '{`ZP_BORDER, `ZP_PAGE0, `ZP_PAGE0 + 8'd1, `ZP_PAGE0 + 8'd2,
                         `ZP_PAGE0 + 8'd3, `ZP_SYSCONF, `ZP_MEMCONF, `ZP_INTMASK};

  logic [31:0] rng;
  logic [31:0] r;
  int     checks;
  int     errors;
  int     t_checks;
  int     t_errors;
  int     req_cnt;
  int     cnt0;
  zdata_t s_dout;
  logic   s_doe;
  maddr_t s_addr;
  logic   s_csrom;
  logic   s_idle_oe;

  zx_top u_zx_top (
    .fclk          (fclk),
    .rst           (rst),
    .a             (a),
    .d_in          (d_in),
    .iorq_n        (iorq_n),
    .mreq_n        (mreq_n),
    .rd_n          (rd_n),
    .wr_n          (wr_n),
    .m1_n          (m1_n),
    .int_start_frm (int_start_frm),
    .int_start_lin (int_start_lin),
    .int_start_dma (int_start_dma),
    .d_out         (d_out),
    .d_oe          (d_oe),
    .int_n         (int_n),
    .mem_addr      (mem_addr),
    .csrom         (csrom),
    .mem_req       (mem_req)
  );

  always #(PERIOD / 2) fclk = ~fclk;

  always @(negedge fclk) begin
    if (!rst && mem_req) req_cnt++;   // one count per pulse
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic next_rand();
    rng = xorshift(rng);
    r   = rng;
  endtask

  function automatic zdata_t model_read(input zdata_t hi);
    case (hi)
      `ZP_BORDER:  return m_border;
      `ZP_SYSCONF: return m_sysconf;
      `ZP_MEMCONF: return m_memconf;
      `ZP_INTMASK: return {5'd0, m_mask};
      `ZP_PAGE0, `ZP_PAGE0 + 8'd1, `ZP_PAGE0 + 8'd2, `ZP_PAGE0 + 8'd3:
        return m_page[hi[1:0]];
      default:     return 8'hFF;
    endcase
  endfunction

  task automatic model_write(input zdata_t hi, input zdata_t v);
    case (hi)
      `ZP_BORDER:  m_border  = v;
      `ZP_SYSCONF: m_sysconf = v;
      `ZP_MEMCONF: m_memconf = v;
      `ZP_INTMASK: m_mask    = v[2:0];
      `ZP_PAGE0, `ZP_PAGE0 + 8'd1, `ZP_PAGE0 + 8'd2, `ZP_PAGE0 + 8'd3:
        m_page[hi[1:0]] = v;
      default: ;
    endcase
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %s got %h expected %h at %0t ns", name, got, exp, $time);
    end
  endtask

  task automatic end_test(input string title);
    $display("test %-24s %0d checks, %0d errors", title, checks - t_checks, errors - t_errors);
    t_checks = checks;
    t_errors = errors;
  endtask

  // 4 clocks held, 3 idle; sampled in the last held clock
  task automatic bus_cycle(input zaddr_t addr, input zdata_t data, input logic io,
                           input logic wr, input logic ack);
    a      = addr;
    d_in   = data;
    iorq_n = ~io;
    mreq_n = io;
    m1_n   = ~ack;
    rd_n   = wr | ack;
    wr_n   = ~wr | ack;
    repeat (3) @(negedge fclk);
    s_dout  = d_out;
    s_doe   = d_oe;
    s_addr  = mem_addr;
    s_csrom = csrom;
    @(negedge fclk);
    iorq_n = 1'b1;
    mreq_n = 1'b1;
    rd_n   = 1'b1;
    wr_n   = 1'b1;
    m1_n   = 1'b1;
    repeat (3) @(negedge fclk);
    s_idle_oe = d_oe;
  endtask

  task automatic io_write(input zdata_t hi, input zdata_t v);
    bus_cycle({hi, `ZP_EXT_LO}, v, 1'b1, 1'b1, 1'b0);
    model_write(hi, v);
    check("d_oe", 32'(s_doe), 32'd0);
  endtask

  task automatic io_read(input zaddr_t addr);
    bus_cycle(addr, 8'h00, 1'b1, 1'b0, 1'b0);
    if (addr[7:0] == `ZP_EXT_LO) begin
      check("d_oe", 32'(s_doe), 32'd1);
      check("d_out", 32'(s_dout), 32'(model_read(addr[15:8])));
    end else begin
      check("d_oe", 32'(s_doe), 32'd0);
    end
    check("d_oe idle", 32'(s_idle_oe), 32'd0);
  endtask

  task automatic mem_access(input zaddr_t addr, input zdata_t v, input logic wr);
    cnt0 = req_cnt;
    bus_cycle(addr, v, 1'b0, wr, 1'b0);
    check("mem_addr", 32'(s_addr), 32'({m_page[addr[15:14]], addr[13:0]}));
    check("csrom", 32'(s_csrom), 32'((addr[15:14] == 2'd0) && m_memconf[0]));
    check("d_oe", 32'(s_doe), 32'd0);
    check("mem_req count", 32'(req_cnt - cnt0), 32'd1);
  endtask

  // bit 0 frame, bit 1 line, bit 2 dma
  task automatic start_pulse(input logic [2:0] set);
    {int_start_dma, int_start_lin, int_start_frm} = set;
    m_pend = m_pend | (set & m_mask);
    @(negedge fclk);
    {int_start_dma, int_start_lin, int_start_frm} = 3'b000;
    @(negedge fclk);
    check("int_n", 32'(int_n), 32'(~|m_pend));
  endtask

  task automatic int_ack(input zaddr_t addr);
    zdata_t vec;
    logic [2:0] src;
    if (m_pend[0]) begin
      vec = `IV_FRAME;
      src = 3'b001;
    end else if (m_pend[1]) begin
      vec = `IV_LINE;
      src = 3'b010;
    end else begin
      vec = `IV_DMA;
      src = 3'b100;
    end
    bus_cycle(addr, 8'h00, 1'b1, 1'b0, 1'b1);
    m_pend = m_pend & ~src;
    check("d_oe", 32'(s_doe), 32'd1);
    check("d_out", 32'(s_dout), 32'(vec));
    check("int_n", 32'(int_n), 32'(~|m_pend));
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, the tests did not finish in time");
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    fclk = 1'b0;
    rst  = 1'b1;
    a    = '0;
    d_in = '0;
    iorq_n = 1'b1;
    mreq_n = 1'b1;
    rd_n   = 1'b1;
    wr_n   = 1'b1;
    m1_n   = 1'b1;
    int_start_frm = 1'b0;
    int_start_lin = 1'b0;
    int_start_dma = 1'b0;
    rng = 32'd32;
    r   = '0;
    checks   = 0;
    errors   = 0;
    t_checks = 0;
    t_errors = 0;
    req_cnt  = 0;
    m_border  = 8'h00;
    m_sysconf = 8'h00;
    m_memconf = `RST_MEMCONF;
    m_mask    = `RST_INTMASK;
    m_page[0] = 8'h00;
    m_page[1] = 8'h01;
    m_page[2] = 8'h02;
    m_page[3] = `RST_PAGE3;
    m_pend    = 3'b000;
    repeat (10) @(negedge fclk);
    rst = 1'b0;

    for (int i = 0; i < 8; i++) io_read({listed[i], `ZP_EXT_LO});
    check("int_n", 32'(int_n), 32'd1);
    end_test("reset values");

    for (int i = 0; i < N_IO; i++) begin
      next_rand();
      case (r[1:0])
        2'd0: io_write(listed[r[4:2]], r[15:8]);
        2'd1: io_read({listed[r[4:2]], `ZP_EXT_LO});
        2'd2: io_read({1'b1, r[14:8], `ZP_EXT_LO});   // 80..FF, none listed
        default: begin
          if (r[23:16] == `ZP_EXT_LO) r[23:16] = 8'hAE;
          if (r[24]) bus_cycle({listed[r[4:2]], r[23:16]}, r[15:8], 1'b1, 1'b1, 1'b0);
          else io_read({r[15:8], r[23:16]});
        end
      endcase
    end
    end_test("io ports");

    for (int i = 0; i < N_MEM; i++) begin
      next_rand();
      if (r[2:0] == 3'd0) io_write(r[3] ? `ZP_MEMCONF : listed[1 + r[5:4]], r[15:8]);
      mem_access(r[31:16], r[15:8], r[6]);
    end
    end_test("memory map");

    io_write(`ZP_INTMASK, 8'h00);
    for (int i = 0; i < 20; i++) begin
      next_rand();
      start_pulse(r[2:0]);   // all masked
    end
    for (int i = 0; i < N_INT; i++) begin
      next_rand();
      if (r[1:0] == 2'd0) io_write(`ZP_INTMASK, r[15:8]);
      start_pulse(r[10:8]);
    end
    end_test("interrupt requests");

    for (int i = 0; i < N_ACK; i++) begin
      next_rand();
      if (m_pend != 3'b000 && r[0]) begin
        int_ack(r[31:16]);
      end else begin
        if (r[3:1] == 3'd0) io_write(`ZP_INTMASK, r[15:8]);
        start_pulse(r[6:4]);
      end
    end
    for (int i = 0; i < 3; i++) begin
      if (m_pend != 3'b000) int_ack(16'h0000);
    end
    check("int_n", 32'(int_n), 32'd1);
    end_test("interrupt acknowledge");

    $display("total %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* zports/zports.sv */
`timescale 1ns/10ps
`default_nettype none
`include "tsconf_defs.svh"

module zports (
  input  logic                 fclk,
  input  logic                 rst,
  input  tsconf_pkg::zaddr_t   a,
  input  tsconf_pkg::zdata_t   d_in,
  input  logic                 iord,
  input  logic                 iowr_s,
  output tsconf_pkg::zdata_t   port_dout,
  output logic                 port_oe,
  output tsconf_pkg::page_t    page0,
  output tsconf_pkg::page_t    page1,
  output tsconf_pkg::page_t    page2,
  output tsconf_pkg::page_t    page3,
  output tsconf_pkg::zdata_t   memconf,
  output tsconf_pkg::intmask_t intmask
);

  import tsconf_pkg::*;

  zdata_t border;
  zdata_t sysconf;
  page_t  pages [4];
  logic   ext_hit;
  zdata_t pg_off;       // high byte relative to first page port
  logic   pg_hit;

  assign ext_hit = (a[7:0] == `ZP_EXT_LO);
  assign pg_off  = a[15:8] - `ZP_PAGE0;
  assign pg_hit  = (pg_off[7:2] == 6'd0);

  always_ff @(posedge fclk) begin
    if (rst) begin
      border   <= '0;
      sysconf  <= '0;
      memconf  <= `RST_MEMCONF;
      intmask  <= `RST_INTMASK;
      pages[0] <= 8'h00;
      pages[1] <= 8'h01;
      pages[2] <= 8'h02;
      pages[3] <= `RST_PAGE3;
    end else if (iowr_s && ext_hit) begin
      case (a[15:8])
        `ZP_BORDER:  border  <= d_in;
        `ZP_SYSCONF: sysconf <= d_in;
        `ZP_MEMCONF: memconf <= d_in;
        `ZP_INTMASK: intmask <= d_in[2:0];
        default: begin
          if (pg_hit) begin
            pages[pg_off[1:0]] <= d_in;
          end
        end
      endcase
    end
  end

  // read back
  always_comb begin
    case (a[15:8])
      `ZP_BORDER:  port_dout = border;
      `ZP_SYSCONF: port_dout = sysconf;
      `ZP_MEMCONF: port_dout = memconf;
      `ZP_INTMASK: port_dout = {5'b00000, intmask};
      default:     port_dout = pg_hit ? pages[pg_off[1:0]] : 8'hFF; // unlisted port
    endcase
  end

  assign port_oe = iord & ext_hit;

  assign page0 = pages[0];
  assign page1 = pages[1];
  assign page2 = pages[2];
  assign page3 = pages[3];

  // no register write while a read drives the bus
  a_no_wr_in_rd: assert property (@(posedge fclk) disable iff (rst) iowr_s |-> !iord);

endmodule

`default_nettype wire

/* zports/zsignals.sv */
`timescale 1ns/10ps
`default_nettype none

module zsignals (
  input  logic fclk,
  input  logic rst,
  input  logic iorq_n,
  input  logic mreq_n,
  input  logic rd_n,
  input  logic wr_n,
  input  logic m1_n,
  output logic iord,
  output logic iowr,
  output logic memrd,
  output logic memwr,
  output logic intack,
  output logic iowr_s,
  output logic mreq_s,
  output logic intack_s
);

  // registered strobes, active high
  logic iorq;
  logic mreq;
  logic rd;
  logic wr;
  logic m1;

  logic iowr_d;
  logic mreq_d;
  logic intack_d;

  always_ff @(posedge fclk) begin
    if (rst) begin
      iorq <= 1'b0;
      mreq <= 1'b0;
      rd   <= 1'b0;
      wr   <= 1'b0;
      m1   <= 1'b0;
    end else begin
      iorq <= ~iorq_n;
      mreq <= ~mreq_n;
      rd   <= ~rd_n;
      wr   <= ~wr_n;
      m1   <= ~m1_n;
    end
  end

  assign iord   = iorq & rd & ~m1;
  assign iowr   = iorq & wr & ~m1;
  assign memrd  = mreq & rd;
  assign memwr  = mreq & wr;
  assign intack = iorq & m1;      // m1 with iorq is the int ack cycle

  // start pulses, one clock behind the levels
  always_ff @(posedge fclk) begin
    if (rst) begin
      iowr_d   <= 1'b0;
      mreq_d   <= 1'b0;
      intack_d <= 1'b0;
      iowr_s   <= 1'b0;
      mreq_s   <= 1'b0;
      intack_s <= 1'b0;
    end else begin
      iowr_d   <= iowr;
      mreq_d   <= mreq;
      intack_d <= intack;
      iowr_s   <= iowr & ~iowr_d;
      mreq_s   <= mreq & ~mreq_d;
      intack_s <= intack & ~intack_d;
    end
  end

  a_rd_wr_excl: assert property (@(posedge fclk) disable iff (rst) !(iord && iowr));

endmodule

`default_nettype wire
